//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scope
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- capture_buffer.sv
// Capture FIFO that records a window of tagged samples after a start pulse and streams them out
`timescale 1ns/1ps

module capture_buffer
    import scope_pkg::*;
#(
    parameter int PERIOD_WIDTH = 16,
    parameter int BUFFER_DEPTH = 64
) (
    input  logic                    clock,
    input  logic                    arst_n,
    scope_sample_if.sink            in,
    input  logic                    capture_start,
    input  logic [PERIOD_WIDTH-1:0] capture_len,
    output sample_t                 out_data,
    output dest_t                   out_dest,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready,
    output logic                    done
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);

    sample_t mem_data [BUFFER_DEPTH];
    dest_t   mem_dest [BUFFER_DEPTH];
    logic    mem_last [BUFFER_DEPTH];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [ADDR_W:0]         wr_ptr;
    logic [ADDR_W:0]         rd_ptr;
    logic [PERIOD_WIDTH-1:0] win_count;
    logic                    armed;
    logic                    full;
    logic                    empty;
    logic                    wr_en;
    logic                    wr_last;
    logic                    rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Outside a window samples are swallowed, so ready stays high
    // Inside one a full FIFO pushes back on the sequencer
    assign in.ready = !armed || !full;
    assign wr_en    = armed && in.valid && !full;
    assign wr_last  = (win_count == capture_len - 1'b1);

    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            win_count <= '0;
            armed     <= 1'b0;
        end else begin
            if (capture_start) begin
                armed     <= 1'b1;
                win_count <= '0;
            end else if (wr_en) begin
                // The write tagged last also closes the window
                if (wr_last) begin
                    armed <= 1'b0;
                end
                win_count <= win_count + 1'b1;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= in.data;
            mem_dest[wr_ptr[ADDR_W-1:0]] <= in.dest;
            mem_last[wr_ptr[ADDR_W-1:0]] <= wr_last;
        end
    end

    // Read side is first-word-fall-through, valid one cycle after the first write
    assign out_valid = !empty;
    assign out_data  = mem_data[rd_ptr[ADDR_W-1:0]];
    assign out_dest  = mem_dest[rd_ptr[ADDR_W-1:0]];

    // Entries that were never written hold no meaningful last bit
    assign out_last = out_valid && mem_last[rd_ptr[ADDR_W-1:0]];
    assign done     = rd_en && out_last;

endmodule

//--- channel_sequencer.sv
// Turns each six-channel conversion into a stream of channel-tagged samples, channel 0 first
`timescale 1ns/1ps

module channel_sequencer
    import scope_pkg::*;
(
    input  logic                     clock,
    input  logic                     arst_n,
    input  sample_t [N_CHANNELS-1:0] samples,
    input  logic                     samples_valid,
    scope_sample_if.source           out,
    output logic                     overrun
);

    localparam dest_t LAST_CH = dest_t'(N_CHANNELS - 1);

    sample_t [N_CHANNELS-1:0] snapshot;
    dest_t                    ch_idx;
    logic                     handshake;
    logic                     busy;
    logic                     accept;

    assign handshake = out.valid && out.ready;

    // Still busy unless the last channel leaves in this very cycle
    assign busy   = out.valid && !(handshake && (ch_idx == LAST_CH));
    assign accept = samples_valid && !busy;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
            ch_idx    <= '0;
            overrun   <= 1'b0;
        end else begin
            if (accept) begin
                out.valid <= 1'b1;
                ch_idx    <= '0;
            end else if (handshake) begin
                if (ch_idx == LAST_CH) begin
                    out.valid <= 1'b0;
                end else begin
                    ch_idx <= ch_idx + 1'b1;
                end
            end
            // A conversion that finds channels pending is dropped whole
            // Sticky until reset
            if (samples_valid && busy) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            snapshot <= samples;
        end
    end

    // Snapshot and index only change on accept or handshake, so data holds while waiting
    assign out.data = snapshot[ch_idx];
    assign out.dest = ch_idx;

endmodule

//--- flist.f
scope_pkg.sv
scope_sample_if.sv
sample_period_counter.sv
spi_adc_reader.sv
channel_sequencer.sv
capture_buffer.sv
scope_top.sv
tb_scope.sv

//--- sample_period_counter.sv
// Sample-period timer that issues a one-cycle conversion tick every period clocks while enabled
`timescale 1ns/1ps

module sample_period_counter #(
    parameter int PERIOD_WIDTH = 16
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    enable,
    input  logic [PERIOD_WIDTH-1:0] period,
    output logic                    tick
);

    logic [PERIOD_WIDTH-1:0] count;
    logic                    wrap;

    // Last count of the period, the next value is zero again
    assign wrap = (count == period - 1'b1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!enable) begin
            // Holding at zero ties the sampling phase to the rising edge of enable
            count <= '0;
            tick  <= 1'b0;
        end else begin
            // Registered, so the first tick shows up one cycle after enable rises
            tick <= (count == '0);
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- scope_pkg.sv
// Shared constants and sample types for the six-channel ADC acquisition path; import with scope_pkg::*
package scope_pkg;

    // Number of ADC channels read in parallel on one SPI frame
    localparam int N_CHANNELS = 6;

    // Bits kept from each conversion result
    localparam int ADC_WIDTH = 14;

    // SCLK cycles per conversion frame
    // The two leading bits on MISO are zero and get discarded
    localparam int SPI_FRAME_BITS = 16;

    // Width of the channel tag carried next to each sample
    localparam int DEST_WIDTH = 3;

    // One ADC result
    typedef logic [ADC_WIDTH-1:0] sample_t;

    // Channel tag, 0 to N_CHANNELS-1
    typedef logic [DEST_WIDTH-1:0] dest_t;

endpackage

//--- scope_sample_if.sv
// Valid/ready link carrying one tagged sample between the sequencer and the capture buffer
`timescale 1ns/1ps

interface scope_sample_if
    import scope_pkg::*;
();

    sample_t data;
    dest_t   dest;
    logic    valid;
    logic    ready;

    // A transfer happens on a rising edge with valid and ready both high
    // The source keeps data and dest steady from valid until that transfer
    modport source (
        output data,
        output dest,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  dest,
        input  valid,
        output ready
    );

endinterface

//--- scope_top.sv
// Top level of the six-channel acquisition block: period timer, SPI reader, sequencer and capture FIFO
`timescale 1ns/1ps

module scope_top
    import scope_pkg::*;
#(
    parameter int PERIOD_WIDTH = 16,
    parameter int BUFFER_DEPTH = 64
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    enable,
    input  logic [PERIOD_WIDTH-1:0] period,
    input  logic                    capture_start,
    input  logic [PERIOD_WIDTH-1:0] capture_len,
    input  logic [N_CHANNELS-1:0]   miso,
    output logic                    ss,
    output logic                    sclk,
    output sample_t                 out_data,
    output dest_t                   out_dest,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_last,
    output logic                    done,
    output logic                    overrun
);

    logic                     tick;
    sample_t [N_CHANNELS-1:0] samples;
    logic                     samples_valid;

    scope_sample_if seq_if ();

    sample_period_counter #(
        .PERIOD_WIDTH(PERIOD_WIDTH)
    ) u_period (
        .clock (clock),
        .arst_n(arst_n),
        .enable(enable),
        .period(period),
        .tick  (tick)
    );

    spi_adc_reader u_reader (
        .clock        (clock),
        .arst_n       (arst_n),
        .tick         (tick),
        .miso         (miso),
        .ss           (ss),
        .sclk         (sclk),
        .samples      (samples),
        .samples_valid(samples_valid)
    );

    channel_sequencer u_sequencer (
        .clock        (clock),
        .arst_n       (arst_n),
        .samples      (samples),
        .samples_valid(samples_valid),
        .out          (seq_if.source),
        .overrun      (overrun)
    );

    capture_buffer #(
        .PERIOD_WIDTH(PERIOD_WIDTH),
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_capture (
        .clock        (clock),
        .arst_n       (arst_n),
        .in           (seq_if.sink),
        .capture_start(capture_start),
        .capture_len  (capture_len),
        .out_data     (out_data),
        .out_dest     (out_dest),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_ready    (out_ready),
        .done         (done)
    );

endmodule

//--- spi_adc_reader.sv
// SPI master that reads one conversion from six ADCs sharing ss and sclk, one MISO line each
`timescale 1ns/1ps

module spi_adc_reader
    import scope_pkg::*;
(
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     tick,
    input  logic [N_CHANNELS-1:0]    miso,
    output logic                     ss,
    output logic                     sclk,
    output sample_t [N_CHANNELS-1:0] samples,
    output logic                     samples_valid
);

    localparam int CNT_W = $clog2(SPI_FRAME_BITS);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FRAME = 2'd1;
    localparam logic [1:0] ST_DONE  = 2'd2;

    logic [1:0]                state;
    logic [CNT_W-1:0]          bit_cnt;
    logic                      shift_en;
    logic [SPI_FRAME_BITS-1:0] shift_reg [N_CHANNELS];

    // MISO is taken on the same edge that drives sclk high
    // The ADC only moves MISO after sclk falls, so it has been stable for a full clock
    assign shift_en = (state == ST_FRAME) && !sclk;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_IDLE;
            ss            <= 1'b1;
            sclk          <= 1'b0;
            bit_cnt       <= '0;
            samples_valid <= 1'b0;
        end else begin
            samples_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Ticks are only looked at here, so a tick during a frame is lost
                    if (tick) begin
                        state   <= ST_FRAME;
                        ss      <= 1'b0;
                        sclk    <= 1'b0;
                        bit_cnt <= '0;
                    end
                end
                ST_FRAME: begin
                    // Each sclk pulse is one clock low followed by one clock high
                    sclk <= !sclk;
                    if (sclk) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(SPI_FRAME_BITS - 1)) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    // 34 cycles after the tick: ss released and results presented
                    ss            <= 1'b1;
                    samples_valid <= 1'b1;
                    state         <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                    ss    <= 1'b1;
                    sclk  <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                shift_reg[ch] <= {shift_reg[ch][SPI_FRAME_BITS-2:0], miso[ch]};
            end
        end
        if (state == ST_DONE) begin
            // The two zero lead bits fall off the top here
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                samples[ch] <= shift_reg[ch][ADC_WIDTH-1:0];
            end
        end
    end

endmodule

//--- tb_scope.sv
// Self-checking testbench for scope_top; run it from flist.f with tb_scope as top module
`timescale 1ns/1ps

module tb_scope
    import scope_pkg::*;
();

    localparam int PERIOD = 48;
    localparam int MARGIN = 1500;

    logic                  clock;
    logic                  arst_n = 1'b0;
    logic                  enable = 1'b0;
    logic [15:0]           period = 16'(PERIOD);
    logic                  capture_start = 1'b0;
    logic [15:0]           capture_len = 16'd24;
    logic [N_CHANNELS-1:0] miso = '0;
    logic                  out_ready = 1'b1;
    logic                  ss;
    logic                  sclk;
    sample_t               out_data;
    dest_t                 out_dest;
    logic                  out_valid;
    logic                  out_last;
    logic                  done;
    logic                  overrun;

    int   errors = 0;
    int   errors_at_start = 0;
    int   tests_ok = 0;
    int   tests_bad = 0;
    int   cycle = 0;
    int   last_fall = -1;
    int   rises = 0;
    int   win_count = 0;
    int   done_count = 0;
    int   prev_n = 0;
    int   prev_dest = 0;
    int   frame = 0;
    int   first_frame = 0;
    // 0 holds out_ready low, 1 holds it high, 2 randomises it
    int   ready_mode = 1;
    logic expect_idle = 1'b0;
    logic expect_no_overrun = 1'b1;
    logic win_open = 1'b0;
    logic first_in_win = 1'b0;
    logic ss_q = 1'b1;
    logic sclk_q = 1'b0;
    logic ss_seen = 1'b1;
    logic [31:0] rng = 32'hb21b;
    logic [SPI_FRAME_BITS-1:0] adc_word [N_CHANNELS];

    scope_top #(
        .PERIOD_WIDTH(16),
        .BUFFER_DEPTH(64)
    ) dut0 (
        .clock(clock), .arst_n(arst_n), .enable(enable), .period(period),
        .capture_start(capture_start), .capture_len(capture_len), .miso(miso),
        .ss(ss), .sclk(sclk), .out_data(out_data), .out_dest(out_dest),
        .out_valid(out_valid), .out_ready(out_ready), .out_last(out_last),
        .done(done), .overrun(overrun)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Value that ADC k converts in frame n
    function automatic int adc_value(input int n, input int k);
        return (n * 37 + k * 1000) % 16384;
    endfunction

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            $display("[test] %s: ok", name);
            tests_ok++;
        end else begin
            $display("[test] %s: %0d errors", name, errors - errors_at_start);
            tests_bad++;
        end
        errors_at_start = errors;
    endtask

    task automatic pulse_capture(input int len);
        // The window opens on the frame now running, or on the next one while ss is high
        first_frame = frame;
        capture_len <= 16'(len);
        @(posedge clock);
        capture_start <= 1'b1;
        @(posedge clock);
        capture_start <= 1'b0;
    endtask

    // Arming at the start of a frame puts channel 0 first in the window
    task automatic start_window(input int len);
        @(negedge ss);
        pulse_capture(len);
    endtask

    task automatic wait_done();
        int d0;
        d0 = done_count;
        while (done_count == d0) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        if (ready_mode == 2) begin
            rng = xorshift(rng);
            out_ready <= rng[0];
        end else begin
            out_ready <= (ready_mode == 1);
        end
    end

    // The ADC puts its first bit out when ss falls and the next one after each falling sclk
    always @(negedge ss or posedge ss or negedge sclk) begin : adc_model
        if (ss !== ss_seen) begin
            if (!ss) begin
                for (int k = 0; k < N_CHANNELS; k++) begin
                    adc_word[k] = 16'(adc_value(frame, k));
                    miso[k] <= adc_word[k][SPI_FRAME_BITS-1];
                end
            end else begin
                frame++;
            end
            ss_seen = ss;
        end else if (!ss) begin
            for (int k = 0; k < N_CHANNELS; k++) begin
                adc_word[k] = adc_word[k] << 1;
                miso[k] <= adc_word[k][SPI_FRAME_BITS-1];
            end
        end
    end

    always @(posedge clock) begin : check_outputs
        int n;
        int data_i;
        int dest_i;
        cycle++;
        if (!arst_n) begin
            if (cycle > 1) begin
                assert (ss && !sclk && !out_valid && !done && !overrun)
                    else report_fail("outputs not at their reset values");
            end
        end else begin
            if (!ss && sclk && !sclk_q) begin
                rises++;
            end
            if (ss && !ss_q) begin
                assert (rises == SPI_FRAME_BITS)
                    else report_fail($sformatf("frame had %0d sclk rising edges", rises));
                rises = 0;
            end
            if (!enable) begin
                last_fall = -1;
            end else if (!ss && ss_q) begin
                if (last_fall >= 0) begin
                    assert (cycle - last_fall == int'(period))
                        else report_fail($sformatf("ss fell %0d cycles after the last frame",
                                                   cycle - last_fall));
                end
                last_fall = cycle;
            end
            if (expect_idle) begin
                assert (ss && !sclk && !out_valid)
                    else report_fail("ADC bus active or sample shown while enable was low");
            end
            if (expect_no_overrun) begin
                assert (!overrun) else report_fail("overrun set without back-pressure");
            end
            if (capture_start) begin
                win_open = 1'b1;
                first_in_win = 1'b1;
                win_count = 0;
            end
            if (out_valid && out_ready) begin
                data_i = int'(out_data);
                dest_i = int'(out_dest);
                if (first_in_win) begin
                    n = first_frame;
                end else if (prev_dest == N_CHANNELS - 1) begin
                    // Frames lost to an overrun leave a gap that only the data shows
                    n = overrun ? data_i / 37 : prev_n + 1;
                end else begin
                    n = prev_n;
                end
                win_count++;
                assert (win_open) else report_fail("sample transferred outside a window");
                assert (data_i == adc_value(n, dest_i))
                    else report_fail($sformatf("data %0d does not fit frame %0d dest %0d",
                                               data_i, n, dest_i));
                if (first_in_win) begin
                    assert (dest_i == 0)
                        else report_fail($sformatf("window opened on dest %0d", dest_i));
                end else if (prev_dest == N_CHANNELS - 1) begin
                    assert (dest_i == 0 && (!overrun || n > prev_n))
                        else report_fail($sformatf("frame %0d dest %0d after frame %0d",
                                                   n, dest_i, prev_n));
                end else begin
                    assert (dest_i == prev_dest + 1)
                        else report_fail($sformatf("dest %0d after dest %0d", dest_i, prev_dest));
                end
                assert (out_last == (win_count == int'(capture_len)))
                    else report_fail($sformatf("out_last %0b on sample %0d", out_last, win_count));
                assert (done == out_last) else report_fail("done differs from out_last");
                if (out_last) begin
                    win_open = 1'b0;
                    done_count++;
                end
                first_in_win = 1'b0;
                prev_dest = dest_i;
                prev_n = n;
            end else begin
                assert (!done) else report_fail("done pulsed without a transfer");
            end
        end
        ss_q = ss;
        sclk_q = sclk;
    end

    initial begin : main
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        repeat (2) @(posedge clock);
        finish_test("reset state");
        enable <= 1'b1;
        start_window(30);
        wait_done();
        finish_test("SPI framing, data and channel order");
        start_window(24);
        wait_done();
        finish_test("capture window of 24");
        ready_mode <= 2;
        start_window(48);
        wait_done();
        finish_test("random back-pressure");
        // Holding out_ready low fills the FIFO and stalls the sequencer
        expect_no_overrun <= 1'b0;
        ready_mode <= 0;
        start_window(120);
        while (!overrun) begin
            @(posedge clock);
        end
        ready_mode <= 1;
        wait_done();
        finish_test("FIFO fill and overrun");
        enable <= 1'b0;
        @(posedge clock);
        while (!ss) begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock);
        expect_idle <= 1'b1;
        pulse_capture(6);
        repeat (4 * PERIOD) @(posedge clock);
        expect_idle <= 1'b0;
        enable <= 1'b1;
        wait_done();
        finish_test("enable gating");
        $display("Summary: %0d ok, %0d with errors, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Budget per window is its frame count times the period, plus margin
    initial begin : watchdog
        int lens [5];
        int budget;
        lens = '{30, 24, 48, 120, 6};
        budget = 16 + 4 * PERIOD;
        foreach (lens[i]) begin
            budget += lens[i] / N_CHANNELS * PERIOD + MARGIN;
        end
        #(budget * 100);
        $display("Watchdog expired after %0d cycles with tests still running", budget);
        $display("test failed");
        $finish;
    end

endmodule
